// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --sv --timing --assert
TOP        := tb_bch_encoder
FILELIST   := tb.f
LOG        := sim.log
FAIL_MSG   := Errors found
PASS_MSG   := No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== bch_cfg_regs.sv ====
`timescale 1ns/1ps

module bch_cfg_regs (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  bch_pkg::wb_req_s  wb_req,
	output bch_pkg::wb_rsp_s  wb_rsp,
	input  logic              frame_done,
	output bch_pkg::bch_mode_s mode
);

	logic        req;
	logic        ack_q;
	logic [31:0] dat_r_q;
	logic [15:0] frame_cnt;

	assign req = wb_req.cyc && wb_req.stb && !ack_q; // New request, not the one being acked

	// ############################################################
	// Control state and counter
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			ack_q     <= 1'b0;
			mode      <= '0;
			frame_cnt <= '0;
		end else begin
			ack_q <= req;
			if (req && wb_req.we && wb_req.adr == bch_pkg::REG_CTRL)
				mode <= bch_pkg::bch_mode_s'(wb_req.dat_w[4:0]);
			if (frame_done && frame_cnt != 16'hFFFF)
				frame_cnt <= frame_cnt + 16'd1; // Saturates at the top
		end
	end

	// Read data is captured with the request and presented with ack
	always_ff @(posedge sys_clk) begin
		if (req) begin
			case (wb_req.adr)
				bch_pkg::REG_CTRL:   dat_r_q <= {27'd0, mode};
				bch_pkg::REG_STATUS: dat_r_q <= {16'd0, frame_cnt};
				default:             dat_r_q <= '0;
			endcase
		end
	end

	assign wb_rsp = '{ack: ack_q, dat_r: dat_r_q};

	// An acknowledge always answers a request seen on the previous clock
	ack_follows_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$rose(ack_q) |-> $past(wb_req.cyc && wb_req.stb));

endmodule

// ==== bch_encoder_top.sv ====
`timescale 1ns/1ps

module bch_encoder_top (
	input  logic                 sys_clk,
	input  logic                 rst_n,
	input  logic                 fs_en,
	input  bch_pkg::stream_in_s  in,
	output logic                 in_ready,
	output bch_pkg::stream_out_s out,
	input  bch_pkg::wb_req_s     wb_req,
	output bch_pkg::wb_rsp_s     wb_rsp
);

	bch_pkg::bch_mode_s cfg_mode;   // Live register value
	bch_pkg::bch_mode_s frame_mode; // Mode of the frame in flight
	bch_pkg::byte_t     lfsr_byte;
	bch_pkg::byte_t     ps_byte;
	bch_pkg::parity_t   remainder;
	logic               frame_done;
	logic               lfsr_clr;
	logic               lfsr_shift;
	logic               frame_vld;
	logic               ps_oe;
	logic               ps_oe_head;

	bch_cfg_regs u_cfg_regs (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.frame_done (frame_done),
		.mode       (cfg_mode)
	);

	bch_frame_ctrl u_frame_ctrl (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.fs_en        (fs_en),
		.in           (in),
		.in_ready     (in_ready),
		.mode         (cfg_mode),
		.lfsr_clr     (lfsr_clr),
		.lfsr_shift   (lfsr_shift),
		.lfsr_byte    (lfsr_byte),
		.frame_mode_q (frame_mode),
		.frame_vld    (frame_vld),
		.ps_oe        (ps_oe),
		.ps_oe_head   (ps_oe_head),
		.ps_byte      (ps_byte),
		.out          (out),
		.frame_done   (frame_done)
	);

	bch_lfsr_byte u_lfsr_byte (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.fs_en     (fs_en),
		.clr       (lfsr_clr),
		.shift     (lfsr_shift),
		.data      (lfsr_byte),
		.mode      (frame_mode),
		.remainder (remainder)
	);

	bchencoder_data_ps u_data_ps (
		.sys_clk   (sys_clk),
		.fs_en     (fs_en),
		.rst_n     (rst_n),
		.frame_vld (frame_vld),
		.mode      (frame_mode),
		.byte_in   (remainder),
		.oe_head   (ps_oe_head),
		.oe        (ps_oe),
		.byte_out  (ps_byte)
	);

endmodule

// ==== bch_frame_ctrl.sv ====
`timescale 1ns/1ps

module bch_frame_ctrl (
	input  logic                 sys_clk,
	input  logic                 rst_n,
	input  logic                 fs_en,
	input  bch_pkg::stream_in_s  in,
	output logic                 in_ready,
	input  bch_pkg::bch_mode_s   mode,
	output logic                 lfsr_clr,
	output logic                 lfsr_shift,
	output bch_pkg::byte_t       lfsr_byte,
	output bch_pkg::bch_mode_s   frame_mode_q,
	output logic                 frame_vld,
	input  logic                 ps_oe,
	input  logic                 ps_oe_head,
	input  bch_pkg::byte_t       ps_byte,
	output bch_pkg::stream_out_s out,
	output logic                 frame_done
);

	bch_pkg::ctrl_state_e state;
	bch_pkg::bch_mode_s   mode_q;
	bch_pkg::byte_t       data_q;
	logic                 data_vld_q;
	logic                 data_sof_q;
	logic [4:0]           par_cnt;
	logic                 xfer;
	logic                 accept;
	logic                 par_vld;
	logic                 par_last;

	assign in_ready = (state != bch_pkg::PARITY);
	assign xfer     = fs_en && in.valid && in_ready;
	assign accept   = xfer && (in.sof || state == bch_pkg::DATA); // Stray bytes before sof are dropped

	// The sof byte already needs the new mode, later bytes use the snapshot
	assign frame_mode_q = (accept && in.sof) ? mode : mode_q;
	assign lfsr_clr     = accept && in.sof;
	assign lfsr_shift   = accept;
	assign lfsr_byte    = in.data;

	assign par_vld    = ps_oe && (state == bch_pkg::PARITY);
	assign par_last   = par_vld && (par_cnt == bch_pkg::parity_bytes(mode_q) - 5'd1);
	assign frame_done = fs_en && par_last;

	// ############################################################
	// Sequencer
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state      <= bch_pkg::IDLE;
			mode_q     <= '0;
			frame_vld  <= 1'b0;
			data_vld_q <= 1'b0;
			data_sof_q <= 1'b0;
			par_cnt    <= '0;
		end else if (fs_en) begin
			frame_vld  <= accept && in.eof; // LFSR holds the final remainder next cycle
			data_vld_q <= accept;
			data_sof_q <= accept && in.sof;
			if (accept && in.sof)
				mode_q <= mode;
			if (frame_vld)
				par_cnt <= '0;
			else if (par_vld)
				par_cnt <= par_cnt + 5'd1;
			case (state)
				bch_pkg::IDLE,
				bch_pkg::DATA: begin
					if (accept && in.eof)
						state <= bch_pkg::PARITY;
					else if (accept)
						state <= bch_pkg::DATA;
				end
				bch_pkg::PARITY: begin
					if (par_last)
						state <= bch_pkg::IDLE; // Input opens again next fs_en cycle
				end
				default: state <= bch_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (fs_en && accept)
			data_q <= in.data;
	end

	// Data bytes and parity bytes never overlap, the parity starts two cycles after frame_vld
	always_comb begin
		out = '0;
		if (data_vld_q) begin
			out.data  = data_q;
			out.valid = 1'b1;
			out.sof   = data_sof_q;
		end else if (par_vld) begin
			out.data        = ps_byte;
			out.valid       = 1'b1;
			out.parity      = 1'b1;
			out.parity_head = ps_oe_head;
			out.eof         = par_last;
		end
	end

	no_input_in_parity: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(state == bch_pkg::PARITY) |-> !(fs_en && in.valid && in_ready));

endmodule

// ==== bch_lfsr_byte.sv ====
`timescale 1ns/1ps

module bch_lfsr_byte (
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic               fs_en,
	input  logic               clr,
	input  logic               shift,
	input  bch_pkg::byte_t     data,
	input  bch_pkg::bch_mode_s mode,
	output bch_pkg::parity_t   remainder
);

	bch_pkg::parity_t gpoly;
	bch_pkg::parity_t mask;
	bch_pkg::parity_t rem_nxt;
	logic [7:0]       deg;
	logic             fb;

	// Generator degree is always eight times the parity byte count
	always_comb begin
		deg  = {bch_pkg::parity_bytes(mode), 3'b000};
		mask = ~({192{1'b1}} << deg);
		if (mode.frame_mode)
			gpoly = bch_pkg::GPOLY_S12;
		else begin
			case (mode.ldpc_mode)
				4'd5, 4'd8:  gpoly = bch_pkg::GPOLY_N10;
				4'd9, 4'd10: gpoly = bch_pkg::GPOLY_N8;
				default:     gpoly = bch_pkg::GPOLY_N12;
			endcase
		end
	end

	// Eight division steps, most significant data bit first
	always_comb begin
		rem_nxt = clr ? '0 : remainder;
		fb      = 1'b0;
		for (int i = 7; i >= 0; i--) begin
			fb      = data[i] ^ rem_nxt[deg - 8'd1];
			rem_nxt = (rem_nxt << 1) & mask;
			if (fb)
				rem_nxt = rem_nxt ^ gpoly;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			remainder <= '0;
		else if (fs_en) begin
			if (shift)
				remainder <= rem_nxt; // With clr this starts from an empty remainder
			else if (clr)
				remainder <= '0;
		end
	end

endmodule

// ==== bch_pkg.sv ====
package bch_pkg;

	// ############################################################
	// Basic types
	// ############################################################

	typedef logic [7:0]   byte_t;      // One stream or parity byte
	typedef logic [3:0]   ldpc_mode_t; // LDPC code rate index
	typedef logic [191:0] parity_t;    // Remainder, right aligned

	typedef struct packed {
		logic       frame_mode; // 0 normal frame, 1 short frame
		ldpc_mode_t ldpc_mode;
	} bch_mode_s;

	typedef struct packed {
		byte_t data;
		logic  valid;
		logic  sof;
		logic  eof;
	} stream_in_s;

	typedef struct packed {
		byte_t data;
		logic  valid;
		logic  sof;
		logic  parity;      // Byte belongs to the appended parity
		logic  parity_head; // First parity byte of the frame
		logic  eof;         // Last parity byte of the frame
	} stream_out_s;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] dat_w;
	} wb_req_s;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_rsp_s;

	typedef enum logic [1:0] {IDLE, DATA, PARITY} ctrl_state_e;

	// Register map, CTRL holds frame_mode in bit 4 and ldpc_mode in bits 3:0
	localparam logic [3:0] REG_CTRL   = 4'h0;
	localparam logic [3:0] REG_STATUS = 4'h4;

	// ############################################################
	// Generator polynomials
	// ############################################################

	// Minimal polynomials g1..g12 of the normal frame code, degree 16 each
	localparam logic [16:0] MPOLY_N [12] = '{
		17'h1002D, 17'h10173, 17'h10FBD, 17'h15A55, 17'h11F2F, 17'h1F7B5,
		17'h1AF65, 17'h17367, 17'h10EA1, 17'h175A7, 17'h13A2D, 17'h11AE3
	};

	// Short frame code works over GF(2^14)
	localparam logic [14:0] MPOLY_S [12] = '{
		15'h402B, 15'h4941, 15'h4647, 15'h5591, 15'h6B55, 15'h6389,
		15'h6CE5, 15'h4F21, 15'h460F, 15'h5A49, 15'h5811, 15'h65EF
	};

	// Multiplies the first count minimal polynomials and drops the leading term
	function automatic parity_t gen_product(input logic short_frame, input int count);
		logic [207:0] acc;
		logic [207:0] prod;
		logic [16:0]  m;
		int           top;
		acc = 208'd1;
		for (int i = 0; i < count; i++) begin
			m = short_frame ? {2'b00, MPOLY_S[i]} : MPOLY_N[i];
			prod = '0;
			for (int j = 0; j < 17; j++) begin
				if (m[j])
					prod = prod ^ (acc << j);
			end
			acc = prod;
		end
		top = short_frame ? count * 14 : count * 16;
		acc[top] = 1'b0;
		return acc[191:0];
	endfunction

	localparam parity_t GPOLY_N8  = gen_product(1'b0, 8);  // t=8, degree 128
	localparam parity_t GPOLY_N10 = gen_product(1'b0, 10); // t=10, degree 160
	localparam parity_t GPOLY_N12 = gen_product(1'b0, 12); // t=12, degree 192
	localparam parity_t GPOLY_S12 = gen_product(1'b1, 12); // Short frame, degree 168

	// Number of parity bytes appended for a given mode
	function automatic logic [4:0] parity_bytes(input bch_mode_s m);
		logic [4:0] n;
		if (m.frame_mode)
			n = 5'd21;
		else begin
			case (m.ldpc_mode)
				4'd5, 4'd8:  n = 5'd20;
				4'd9, 4'd10: n = 5'd16;
				default:     n = 5'd24;
			endcase
		end
		return n;
	endfunction

endpackage

// ==== bchencoder_data_ps.sv ====
`timescale 1ns/1ps

module bchencoder_data_ps (
	input  logic               sys_clk,
	input  logic               fs_en,
	input  logic               rst_n,
	input  logic               frame_vld,
	input  bch_pkg::bch_mode_s mode,
	input  bch_pkg::parity_t   byte_in,
	output logic               oe_head,
	output logic               oe,
	output bch_pkg::byte_t     byte_out
);

	logic [4:0]       byte_num;    // Parity byte count minus one
	logic [4:0]       byte_cnt;
	logic             frame_vld_d;
	bch_pkg::parity_t byte_in_tmp;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			byte_num    <= '0;
			byte_cnt    <= '0;
			frame_vld_d <= 1'b0;
		end else if (fs_en) begin
			byte_num    <= bch_pkg::parity_bytes(mode) - 5'd1;
			frame_vld_d <= frame_vld;
			if (frame_vld || byte_cnt == byte_num)
				byte_cnt <= '0; // Counter realigns to every new frame
			else
				byte_cnt <= byte_cnt + 5'd1;
		end
	end

	// ############################################################
	// Parity shift register and output tap
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (fs_en) begin
			if (frame_vld)
				byte_in_tmp <= byte_in;
			else
				byte_in_tmp <= {byte_in_tmp[183:0], 8'h00};
		end
	end

	// Tap sits at the top byte of the remainder for the selected degree
	always_ff @(posedge sys_clk) begin
		if (fs_en) begin
			if (mode.frame_mode)
				byte_out <= byte_in_tmp[167:160];
			else begin
				case (mode.ldpc_mode)
					4'd5, 4'd8:  byte_out <= byte_in_tmp[159:152];
					4'd9, 4'd10: byte_out <= byte_in_tmp[127:120];
					default:     byte_out <= byte_in_tmp[191:184];
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			oe      <= 1'b0;
			oe_head <= 1'b0;
		end else if (fs_en) begin
			if (byte_cnt == 5'd0) begin
				oe      <= frame_vld_d; // Window opens or closes only at a wrap
				oe_head <= frame_vld_d;
			end else
				oe_head <= 1'b0;
		end
	end

	head_inside_window: assert property (@(posedge sys_clk) disable iff (!rst_n)
		oe_head |-> oe);

endmodule

// ==== tb.f ====
bch_pkg.sv
bch_cfg_regs.sv
bch_frame_ctrl.sv
bch_lfsr_byte.sv
bchencoder_data_ps.sv
bch_encoder_top.sv
tb_clk_gen.sv
tb_bch_model.sv
tb_bch_encoder.sv

// ==== tb_bch_encoder.sv ====
`timescale 1ns/1ps

module tb_bch_encoder;

	localparam int NUM_FRAMES = 10;
	localparam int MAX_LEN    = 40;

	logic                 sys_clk;
	logic                 rst_n;
	logic                 fs_en;
	bch_pkg::stream_in_s  in;
	logic                 in_ready;
	bch_pkg::stream_out_s out;
	bch_pkg::wb_req_s     wb_req;
	bch_pkg::wb_rsp_s     wb_rsp;

	int         seed        = 62721;
	int         cycle_cnt   = 0;
	int         cycle_limit = 0;
	int         frame_len [NUM_FRAMES];
	logic [7:0] frame_data [NUM_FRAMES][MAX_LEN];

	// Mode written before each frame, and a second write in the middle of frames 7 and 8
	bit         pre_en   [NUM_FRAMES] = '{0, 1, 1, 1, 1, 1, 1, 0, 0, 0};
	logic [4:0] pre_mode [NUM_FRAMES] = '{5'h00, 5'h05, 5'h08, 5'h09, 5'h0A,
		5'h02, 5'h13, 5'h00, 5'h00, 5'h00};
	bit         mid_en   [NUM_FRAMES] = '{0, 0, 0, 0, 0, 0, 0, 1, 1, 0};
	logic [4:0] mid_mode [NUM_FRAMES] = '{5'h00, 5'h00, 5'h00, 5'h00, 5'h00,
		5'h00, 5'h00, 5'h09, 5'h05, 5'h00};

	bch_pkg::bch_mode_s cur_mode = '0; // Last value written to the register
	bch_pkg::bch_mode_s exp_mode = '0; // Mode of the frame in flight
	logic               in_xfer;
	logic               pending_data;
	logic [7:0]         last_byte;
	logic               last_sof;
	logic               eof_window;
	logic [4:0]         par_seen;
	logic [4:0]         exp_len;
	int                 eof_count;
	logic [191:0]       model_rem;

	tb_clk_gen i_clk_gen (
		.sys_clk (sys_clk),
		.rst_n   (rst_n)
	);

	bch_encoder_top i_bch_encoder_top (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.fs_en    (fs_en),
		.in       (in),
		.in_ready (in_ready),
		.out      (out),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp)
	);

	tb_bch_model i_model (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.en       (fs_en && out.valid),
		.first    (out.sof),
		.data     (out.data),
		.mode     (exp_mode),
		.rem_next (model_rem)
	);

	task automatic fail_value(input string name, input logic [191:0] got,
		input logic [191:0] want);
		$display("FAILED %s: got %0h, expected %0h", name, got, want);
		$display("Errors found");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic fail_text(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "Stopped at the first error");
	endtask

	// Parity length rule of the standard
	function automatic logic [4:0] parity_count_for(input bch_pkg::bch_mode_s m);
		if (m.frame_mode)
			return 5'd21;
		case (m.ldpc_mode)
			4'd5, 4'd8:  return 5'd20;
			4'd9, 4'd10: return 5'd16;
			default:     return 5'd24;
		endcase
	endfunction

	assign in_xfer = fs_en && in.valid && in_ready;
	assign exp_len = parity_count_for(exp_mode);

	// ############################################################
	// Scoreboard state
	// ############################################################

	always @(posedge sys_clk) begin
		if (!rst_n) begin
			pending_data <= 1'b0;
			eof_window   <= 1'b0;
			par_seen     <= '0;
			eof_count    <= 0;
		end else if (fs_en) begin
			pending_data <= in_xfer; // Owed on the output at the next fs_en edge
			if (in_xfer) begin
				last_byte <= in.data;
				last_sof  <= in.sof;
			end
			if (in_xfer && in.eof)
				eof_window <= 1'b1;
			else if (out.valid && out.eof)
				eof_window <= 1'b0;
			if (out.valid && out.eof) begin
				par_seen  <= '0;
				eof_count <= eof_count + 1;
			end else if (out.valid && out.parity)
				par_seen <= par_seen + 5'd1;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run went past %0d cycles", cycle_limit);
			$display("Errors found");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	// fs_en is high on about three cycles out of four
	always @(posedge sys_clk) begin
		#1 fs_en = ($random(seed) & 3) != 0;
	end

	// ############################################################
	// Checks
	// ############################################################

	data_present: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && pending_data |-> out.valid)
		else fail_text("No output byte in the fs_en cycle after a data byte transferred");

	data_value: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && pending_data |-> out.data == last_byte)
		else fail_value("out.data", $sampled(out.data), $sampled(last_byte));

	data_sof: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && pending_data |-> out.sof == last_sof)
		else fail_value("out.sof", $sampled(out.sof), $sampled(last_sof));

	data_flags: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && pending_data |-> !out.parity && !out.parity_head && !out.eof)
		else fail_value("{out.parity, out.parity_head, out.eof}",
			$sampled({out.parity, out.parity_head, out.eof}), 0);

	data_expected: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && out.valid && !out.parity |-> pending_data)
		else fail_text("Data byte on the output with no byte accepted before it");

	parity_eof: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && out.valid && out.parity |-> out.eof == (par_seen == exp_len - 5'd1))
		else fail_value("out.eof", $sampled(out.eof), $sampled(par_seen == exp_len - 5'd1));

	parity_head: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && out.valid && out.parity |-> out.parity_head == (par_seen == 5'd0))
		else fail_value("out.parity_head", $sampled(out.parity_head), $sampled(par_seen == 0));

	codeword_zero: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fs_en && out.valid && out.eof |-> model_rem == '0)
		else fail_value("model_rem", $sampled(model_rem), 0);

	stall_in_parity: assert property (@(posedge sys_clk) disable iff (!rst_n)
		eof_window |-> !in_xfer)
		else fail_text("Input byte accepted between the eof input and the eof output");

	ack_single: assert property (@(posedge sys_clk) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
		else fail_text("Wishbone ack lasted more than one cycle");

	// ############################################################
	// Stimulus tasks
	// ############################################################

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: 32'd0};
		do @(posedge sys_clk); while (!wb_rsp.ack);
		data = wb_rsp.dat_r;
		#1 wb_req = '0;
	endtask

	task automatic write_mode(input logic [4:0] value);
		logic [31:0] rd;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: bch_pkg::REG_CTRL,
			dat_w: {27'd0, value}};
		do @(posedge sys_clk); while (!wb_rsp.ack);
		#1 wb_req = '0;
		cur_mode = bch_pkg::bch_mode_s'(value);
		wb_read(bch_pkg::REG_CTRL, rd);
		assert (rd == {27'd0, value}) else fail_value("wb_rsp.dat_r", rd, {27'd0, value});
	endtask

	task automatic check_status(input int frames);
		logic [31:0] rd;
		wb_read(bch_pkg::REG_STATUS, rd);
		assert (rd == frames) else fail_value("wb_rsp.dat_r", rd, frames);
	endtask

	// Holds the byte until it transfers
	task automatic send_byte(input logic [7:0] d, input logic s, input logic e);
		in = '{data: d, valid: 1'b1, sof: s, eof: e};
		do @(posedge sys_clk); while (!(fs_en && in_ready));
		if (s)
			exp_mode <= cur_mode;
		#1 in = '0;
	endtask

	task automatic send_frame(input int f);
		for (int b = 0; b < frame_len[f]; b++) begin
			send_byte(frame_data[f][b], b == 0, b == frame_len[f] - 1);
			if (mid_en[f] && b == (frame_len[f] - 1) / 2)
				write_mode(mid_mode[f]); // Applies from the next frame on
		end
	endtask

	task automatic wait_frames(input int frames);
		while (eof_count != frames)
			@(posedge sys_clk);
		#1;
	endtask

	initial begin
		int total;
		total  = 0;
		in     = '0;
		fs_en  = 1'b0;
		wb_req = '0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			frame_len[f] = 1 + (($random(seed) & 32'h7FFF_FFFF) % MAX_LEN);
			for (int b = 0; b < MAX_LEN; b++)
				frame_data[f][b] = 8'($random(seed));
		end
		frame_len[0]              = 1;
		frame_len[NUM_FRAMES - 1] = MAX_LEN;
		if (frame_len[7] < 4)
			frame_len[7] = 4;
		if (frame_len[8] < 4)
			frame_len[8] = 4;
		for (int f = 0; f < NUM_FRAMES; f++)
			total += frame_len[f] + 24; // Worst case parity length
		cycle_limit = 5 * total + 2000;

		wait (rst_n === 1'b1);
		check_status(0);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			if (pre_en[f])
				write_mode(pre_mode[f]);
			send_frame(f);
			if (f == 4) begin
				wait_frames(5);
				check_status(5);
			end
		end
		wait_frames(NUM_FRAMES);
		check_status(NUM_FRAMES);
		$display("No errors");
		$finish;
	end

endmodule

// ==== tb_bch_model.sv ====
`timescale 1ns/1ps

module tb_bch_model (
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic               en,
	input  logic               first,
	input  logic [7:0]         data,
	input  bch_pkg::bch_mode_s mode,
	output logic [191:0]       rem_next
);

	// Minimal polynomials from the standard tables, leading term included
	logic [16:0]  min_n [12] = '{
		17'h1002D, 17'h10173, 17'h10FBD, 17'h15A55, 17'h11F2F, 17'h1F7B5,
		17'h1AF65, 17'h17367, 17'h10EA1, 17'h175A7, 17'h13A2D, 17'h11AE3
	};
	logic [14:0]  min_s [12] = '{
		15'h402B, 15'h4941, 15'h4647, 15'h5591, 15'h6B55, 15'h6389,
		15'h6CE5, 15'h4F21, 15'h460F, 15'h5A49, 15'h5811, 15'h65EF
	};
	logic [192:0] gen_n8;
	logic [192:0] gen_n10;
	logic [192:0] gen_n12;
	logic [192:0] gen_s12;
	logic [192:0] gen;
	logic [192:0] r;
	logic [191:0] rem_q;
	int           deg;

	function automatic logic [192:0] poly_mult(input logic [192:0] a, input logic [16:0] m);
		logic [192:0] res;
		res = '0;
		for (int k = 0; k < 193; k++) begin
			if (a[k])
				res = res ^ ({176'd0, m} << k);
		end
		return res;
	endfunction

	function automatic logic [192:0] build_gen(input bit short_frame, input int count);
		logic [192:0] g;
		g = 193'd1;
		for (int i = 0; i < count; i++)
			g = poly_mult(g, short_frame ? {2'b00, min_s[i]} : min_n[i]);
		return g;
	endfunction

	initial begin
		gen_n8  = build_gen(1'b0, 8);
		gen_n10 = build_gen(1'b0, 10);
		gen_n12 = build_gen(1'b0, 12);
		gen_s12 = build_gen(1'b1, 12);
	end

	// Whole codeword divided bit by bit, new bits enter at the bottom
	always_comb begin
		if (mode.frame_mode) begin
			gen = gen_s12;
			deg = 168;
		end else if (mode.ldpc_mode == 4'd5 || mode.ldpc_mode == 4'd8) begin
			gen = gen_n10;
			deg = 160;
		end else if (mode.ldpc_mode == 4'd9 || mode.ldpc_mode == 4'd10) begin
			gen = gen_n8;
			deg = 128;
		end else begin
			gen = gen_n12;
			deg = 192;
		end
		r = first ? '0 : {1'b0, rem_q};
		for (int b = 7; b >= 0; b--) begin
			r = {r[191:0], data[b]};
			if (r[deg])
				r = r ^ gen;
		end
		rem_next = r[191:0];
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			rem_q <= '0;
		else if (en)
			rem_q <= rem_next;
	end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic sys_clk,
	output logic rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk; // 4 ns period
	end

	// Reset is seen low on three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge sys_clk);
		#1 rst_n = 1'b1;
	end

endmodule
